// File: verilog/cp0_pkg.sv
package cp0_pkg;

	localparam int REG_W = 32;
	localparam int ADDR_W = 5;
	localparam int INT_W = 6;

	// register addresses
	localparam logic [ADDR_W-1:0] CP0_BADVADDR = 5'd8;
	localparam logic [ADDR_W-1:0] CP0_COUNT = 5'd9;
	localparam logic [ADDR_W-1:0] CP0_COMPARE = 5'd11;
	localparam logic [ADDR_W-1:0] CP0_STATUS = 5'd12;
	localparam logic [ADDR_W-1:0] CP0_CAUSE = 5'd13;
	localparam logic [ADDR_W-1:0] CP0_EPC = 5'd14;
	localparam logic [ADDR_W-1:0] CP0_PRID = 5'd15;
	localparam logic [ADDR_W-1:0] CP0_CONFIG = 5'd16;

	// exception types as reported by the pipeline
	localparam logic [REG_W-1:0] EXC_T_INT = 32'h00000001;
	localparam logic [REG_W-1:0] EXC_T_ADEL = 32'h00000004;
	localparam logic [REG_W-1:0] EXC_T_ADES = 32'h00000005;
	localparam logic [REG_W-1:0] EXC_T_SYS = 32'h00000008;
	localparam logic [REG_W-1:0] EXC_T_BP = 32'h00000009;
	localparam logic [REG_W-1:0] EXC_T_RI = 32'h0000000a;
	localparam logic [REG_W-1:0] EXC_T_OV = 32'h0000000c;
	localparam logic [REG_W-1:0] EXC_T_TR = 32'h0000000d;
	localparam logic [REG_W-1:0] EXC_T_ERET = 32'h0000000e;

	// Cause.ExcCode values
	localparam logic [4:0] EXCCODE_INT = 5'd0;
	localparam logic [4:0] EXCCODE_ADEL = 5'd4;
	localparam logic [4:0] EXCCODE_ADES = 5'd5;
	localparam logic [4:0] EXCCODE_SYS = 5'd8;
	localparam logic [4:0] EXCCODE_BP = 5'd9;
	localparam logic [4:0] EXCCODE_RI = 5'd10;
	localparam logic [4:0] EXCCODE_OV = 5'd12;
	localparam logic [4:0] EXCCODE_TR = 5'd13;

	localparam logic [REG_W-1:0] STATUS_RST = 32'h00400000;
	localparam logic [REG_W-1:0] CONFIG_RST = 32'h00008000;
	localparam logic [REG_W-1:0] PRID_VAL = 32'h004c0102;
	localparam logic [REG_W-1:0] CAUSE_WMASK = 32'h00c00300; // IV, WP, IP1..0

	// applies one write lane to a register, only the bits in wmask change
	function automatic logic [REG_W-1:0] lane_wr(
		input logic [REG_W-1:0] cur,
		input logic we,
		input logic [ADDR_W-1:0] waddr,
		input logic [ADDR_W-1:0] target,
		input logic [REG_W-1:0] wdata,
		input logic [REG_W-1:0] wmask
	);
		if (we && waddr == target) begin
			return (cur & ~wmask) | (wdata & wmask);
		end
		return cur;
	endfunction

endpackage

// File: verilog/cp0_slot_if.sv
`timescale 1ns/10ps

interface cp0_slot_if;

	logic we;
	logic [cp0_pkg::ADDR_W-1:0] waddr;
	logic [cp0_pkg::REG_W-1:0] wdata;
	logic [cp0_pkg::REG_W-1:0] excepttype;
	logic [cp0_pkg::REG_W-1:0] pc;
	logic in_delay;
	logic [cp0_pkg::REG_W-1:0] bad_addr; // faulting data or fetch address

	modport src (
		output we,
		output waddr,
		output wdata,
		output excepttype,
		output pc,
		output in_delay,
		output bad_addr
	);

	modport arbiter (
		input we,
		input waddr,
		input wdata,
		input excepttype,
		input pc,
		input in_delay,
		input bad_addr
	);

endinterface

// File: verilog/cp0_commit_if.sv
`timescale 1ns/10ps

interface cp0_commit_if;

	logic en; // low while held
	logic wr1_we;
	logic [cp0_pkg::ADDR_W-1:0] wr1_waddr;
	logic [cp0_pkg::REG_W-1:0] wr1_wdata;
	logic wr2_we;
	logic [cp0_pkg::ADDR_W-1:0] wr2_waddr;
	logic [cp0_pkg::REG_W-1:0] wr2_wdata;
	logic exc_valid;
	logic eret;
	logic [4:0] exccode;
	logic [cp0_pkg::REG_W-1:0] epc;
	logic bd;
	logic bad_valid;
	logic [cp0_pkg::REG_W-1:0] bad_addr;

	modport source (
		output en, wr1_we, wr1_waddr, wr1_wdata, wr2_we, wr2_waddr, wr2_wdata,
		output exc_valid, eret, exccode, epc, bd, bad_valid, bad_addr
	);

	modport sink (
		input en, wr1_we, wr1_waddr, wr1_wdata, wr2_we, wr2_waddr, wr2_wdata,
		input exc_valid, eret, exccode, epc, bd, bad_valid, bad_addr
	);

endinterface

// File: verilog/cp0_slot_arbiter.sv
`timescale 1ns/10ps

module cp0_slot_arbiter (
	input logic clk,
	input logic rst_n_i,
	input logic hold_i,
	cp0_slot_if.arbiter slot1,
	cp0_slot_if.arbiter slot2,
	cp0_commit_if.source commit
);

	logic [6:0] dec1;
	logic [6:0] dec2;
	logic [6:0] dec_sel;
	logic use1;
	logic [cp0_pkg::REG_W-1:0] pc_sel;
	logic dly_sel;
	logic [cp0_pkg::REG_W-1:0] bad_sel;

	// {exception, eret, exccode}
	function automatic logic [6:0] exc_decode(input logic [cp0_pkg::REG_W-1:0] etype);
		case (etype)
			cp0_pkg::EXC_T_INT: return {2'b10, cp0_pkg::EXCCODE_INT};
			cp0_pkg::EXC_T_ADEL: return {2'b10, cp0_pkg::EXCCODE_ADEL};
			cp0_pkg::EXC_T_ADES: return {2'b10, cp0_pkg::EXCCODE_ADES};
			cp0_pkg::EXC_T_SYS: return {2'b10, cp0_pkg::EXCCODE_SYS};
			cp0_pkg::EXC_T_BP: return {2'b10, cp0_pkg::EXCCODE_BP};
			cp0_pkg::EXC_T_RI: return {2'b10, cp0_pkg::EXCCODE_RI};
			cp0_pkg::EXC_T_OV: return {2'b10, cp0_pkg::EXCCODE_OV};
			cp0_pkg::EXC_T_TR: return {2'b10, cp0_pkg::EXCCODE_TR};
			cp0_pkg::EXC_T_ERET: return {2'b01, 5'd0};
			default: return 7'd0;
		endcase
	endfunction

	assign dec1 = exc_decode(slot1.excepttype);
	assign dec2 = exc_decode(slot2.excepttype);
	assign use1 = dec1[6] | dec1[5]; // older slot goes first

	assign dec_sel = use1 ? dec1 : dec2;
	assign pc_sel = use1 ? slot1.pc : slot2.pc;
	assign dly_sel = use1 ? slot1.in_delay : slot2.in_delay;
	assign bad_sel = use1 ? slot1.bad_addr : slot2.bad_addr;

	assign commit.exc_valid = dec_sel[6];
	assign commit.eret = dec_sel[5];
	assign commit.exccode = dec_sel[4:0];
	assign commit.epc = dly_sel ? pc_sel - 32'd4 : pc_sel; // point back at the branch
	assign commit.bd = dly_sel;
	assign commit.bad_valid = dec_sel[6] && (dec_sel[4:0] == cp0_pkg::EXCCODE_ADEL ||
		dec_sel[4:0] == cp0_pkg::EXCCODE_ADES);
	assign commit.bad_addr = bad_sel;

	// stall only matters when something would be written
	assign commit.en = !(hold_i && (slot1.we || slot2.we));

	assign commit.wr1_we = slot1.we;
	assign commit.wr1_waddr = slot1.waddr;
	assign commit.wr1_wdata = slot1.wdata;
	assign commit.wr2_we = slot2.we;
	assign commit.wr2_waddr = slot2.waddr;
	assign commit.wr2_wdata = slot2.wdata;

	a_exc_eret_excl: assert property (
		@(posedge clk) disable iff (!rst_n_i) !(commit.exc_valid && commit.eret)
	);

endmodule

// File: verilog/cp0_timer.sv
`timescale 1ns/10ps

module cp0_timer (
	input logic clk,
	input logic rst_n_i,
	cp0_commit_if.sink commit,
	output logic [cp0_pkg::REG_W-1:0] count_o,
	output logic [cp0_pkg::REG_W-1:0] compare_o,
	output logic timer_int_o
);

	logic [cp0_pkg::REG_W:0] cnt_r; // lsb divides by two
	logic [cp0_pkg::REG_W-1:0] compare_r;
	logic cnt_we;
	logic cmp_we;
	logic [cp0_pkg::REG_W-1:0] cnt_wdata;
	logic [cp0_pkg::REG_W-1:0] cmp_nxt;

	assign count_o = cnt_r[cp0_pkg::REG_W:1];
	assign compare_o = compare_r;

	assign cnt_we = (commit.wr1_we && commit.wr1_waddr == cp0_pkg::CP0_COUNT) ||
		(commit.wr2_we && commit.wr2_waddr == cp0_pkg::CP0_COUNT);
	assign cmp_we = (commit.wr1_we && commit.wr1_waddr == cp0_pkg::CP0_COMPARE) ||
		(commit.wr2_we && commit.wr2_waddr == cp0_pkg::CP0_COMPARE);

	// lane 2 outermost so it wins
	assign cnt_wdata = cp0_pkg::lane_wr(
		cp0_pkg::lane_wr(count_o, commit.wr1_we, commit.wr1_waddr, cp0_pkg::CP0_COUNT,
			commit.wr1_wdata, '1),
		commit.wr2_we, commit.wr2_waddr, cp0_pkg::CP0_COUNT, commit.wr2_wdata, '1);
	assign cmp_nxt = cp0_pkg::lane_wr(
		cp0_pkg::lane_wr(compare_r, commit.wr1_we, commit.wr1_waddr, cp0_pkg::CP0_COMPARE,
			commit.wr1_wdata, '1),
		commit.wr2_we, commit.wr2_waddr, cp0_pkg::CP0_COMPARE, commit.wr2_wdata, '1);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_r <= '0;
			compare_r <= '0;
			timer_int_o <= 1'b0;
		end else if (commit.en) begin
			if (cnt_we) begin
				cnt_r <= {cnt_wdata, 1'b0}; // restart divider
			end else begin
				cnt_r <= cnt_r + 1'b1;
			end
			compare_r <= cmp_nxt;
			if (cmp_we) begin
				timer_int_o <= 1'b0; // compare write acks
			end else if (compare_r != '0 && count_o == compare_r) begin
				timer_int_o <= 1'b1;
			end
		end
	end

	a_no_int_on_zero_cmp: assert property (
		@(posedge clk) disable iff (!rst_n_i) $rose(timer_int_o) |-> compare_r != '0
	);

endmodule

// File: verilog/cp0_regs.sv
`timescale 1ns/10ps

module cp0_regs (
	input logic clk,
	input logic rst_n_i,
	cp0_commit_if.sink commit,
	input logic [cp0_pkg::INT_W-1:0] int_i,
	input logic timer_int_i,
	input logic [cp0_pkg::REG_W-1:0] count_i,
	input logic [cp0_pkg::REG_W-1:0] compare_i,
	input logic [cp0_pkg::ADDR_W-1:0] raddr1_i,
	input logic [cp0_pkg::ADDR_W-1:0] raddr2_i,
	output logic [cp0_pkg::REG_W-1:0] rdata1_o,
	output logic [cp0_pkg::REG_W-1:0] rdata2_o,
	output logic [cp0_pkg::REG_W-1:0] status_o,
	output logic [cp0_pkg::REG_W-1:0] cause_o,
	output logic [cp0_pkg::REG_W-1:0] epc_o
);

	logic [cp0_pkg::REG_W-1:0] badvaddr_r;
	logic [cp0_pkg::REG_W-1:0] status_lw;
	logic [cp0_pkg::REG_W-1:0] cause_lw;
	logic [cp0_pkg::REG_W-1:0] epc_lw;
	logic [cp0_pkg::INT_W-1:0] ip_hw;

	// both lanes applied in order, lane 2 last
	assign status_lw = cp0_pkg::lane_wr(
		cp0_pkg::lane_wr(status_o, commit.wr1_we, commit.wr1_waddr, cp0_pkg::CP0_STATUS,
			commit.wr1_wdata, '1),
		commit.wr2_we, commit.wr2_waddr, cp0_pkg::CP0_STATUS, commit.wr2_wdata, '1);

	assign cause_lw = cp0_pkg::lane_wr(
		cp0_pkg::lane_wr(cause_o, commit.wr1_we, commit.wr1_waddr, cp0_pkg::CP0_CAUSE,
			commit.wr1_wdata, cp0_pkg::CAUSE_WMASK),
		commit.wr2_we, commit.wr2_waddr, cp0_pkg::CP0_CAUSE, commit.wr2_wdata,
		cp0_pkg::CAUSE_WMASK);

	assign epc_lw = cp0_pkg::lane_wr(
		cp0_pkg::lane_wr(epc_o, commit.wr1_we, commit.wr1_waddr, cp0_pkg::CP0_EPC,
			commit.wr1_wdata, '1),
		commit.wr2_we, commit.wr2_waddr, cp0_pkg::CP0_EPC, commit.wr2_wdata, '1);

	// timer shares the top hardware line
	assign ip_hw = int_i | {timer_int_i, {(cp0_pkg::INT_W-1){1'b0}}};

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			status_o <= cp0_pkg::STATUS_RST;
			cause_o <= '0;
			epc_o <= '0;
			badvaddr_r <= '0;
		end else if (commit.en) begin
			status_o <= status_lw;
			cause_o <= {cause_lw[31:16], ip_hw, cause_lw[9:0]};
			epc_o <= epc_lw;
			if (commit.exc_valid) begin
				status_o[1] <= 1'b1; // EXL
				cause_o[31] <= commit.bd;
				cause_o[6:2] <= commit.exccode;
				epc_o <= commit.epc; // overrides a lane write
				if (commit.bad_valid) begin
					badvaddr_r <= commit.bad_addr;
				end
			end else if (commit.eret) begin
				status_o[1] <= 1'b0;
			end
		end
	end

	function automatic logic [cp0_pkg::REG_W-1:0] rd_sel(
		input logic [cp0_pkg::ADDR_W-1:0] addr
	);
		case (addr)
			cp0_pkg::CP0_BADVADDR: return badvaddr_r;
			cp0_pkg::CP0_COUNT: return count_i;
			cp0_pkg::CP0_COMPARE: return compare_i;
			cp0_pkg::CP0_STATUS: return status_o;
			cp0_pkg::CP0_CAUSE: return cause_o;
			cp0_pkg::CP0_EPC: return epc_o;
			cp0_pkg::CP0_PRID: return cp0_pkg::PRID_VAL;
			cp0_pkg::CP0_CONFIG: return cp0_pkg::CONFIG_RST; // read only
			default: return '0;
		endcase
	endfunction

	always_comb begin
		rdata1_o = rd_sel(raddr1_i);
		rdata2_o = rd_sel(raddr2_i);
	end

	a_exl_after_exc: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		commit.en && commit.exc_valid |=> status_o[1]
	);

endmodule

// File: verilog/cp0_top.sv
`timescale 1ns/10ps

module cp0_top (
	input logic clk,
	input logic rst_n_i,
	input logic hold_i,
	input logic we1_i,
	input logic [cp0_pkg::ADDR_W-1:0] waddr1_i,
	input logic [cp0_pkg::REG_W-1:0] wdata1_i,
	input logic [cp0_pkg::REG_W-1:0] excepttype1_i,
	input logic [cp0_pkg::REG_W-1:0] pc1_i,
	input logic in_delay1_i,
	input logic [cp0_pkg::REG_W-1:0] bad_addr1_i,
	input logic we2_i,
	input logic [cp0_pkg::ADDR_W-1:0] waddr2_i,
	input logic [cp0_pkg::REG_W-1:0] wdata2_i,
	input logic [cp0_pkg::REG_W-1:0] excepttype2_i,
	input logic [cp0_pkg::REG_W-1:0] pc2_i,
	input logic in_delay2_i,
	input logic [cp0_pkg::REG_W-1:0] bad_addr2_i,
	input logic [cp0_pkg::INT_W-1:0] int_i,
	input logic [cp0_pkg::ADDR_W-1:0] raddr1_i,
	input logic [cp0_pkg::ADDR_W-1:0] raddr2_i,
	output logic [cp0_pkg::REG_W-1:0] rdata1_o,
	output logic [cp0_pkg::REG_W-1:0] rdata2_o,
	output logic [cp0_pkg::REG_W-1:0] status_o,
	output logic [cp0_pkg::REG_W-1:0] cause_o,
	output logic [cp0_pkg::REG_W-1:0] epc_o,
	output logic [cp0_pkg::REG_W-1:0] count_o,
	output logic timer_int_o
);

	logic [cp0_pkg::REG_W-1:0] compare;

	cp0_slot_if slot1_if();
	cp0_slot_if slot2_if();
	cp0_commit_if commit_if();

	assign slot1_if.we = we1_i;
	assign slot1_if.waddr = waddr1_i;
	assign slot1_if.wdata = wdata1_i;
	assign slot1_if.excepttype = excepttype1_i;
	assign slot1_if.pc = pc1_i;
	assign slot1_if.in_delay = in_delay1_i;
	assign slot1_if.bad_addr = bad_addr1_i;

	assign slot2_if.we = we2_i;
	assign slot2_if.waddr = waddr2_i;
	assign slot2_if.wdata = wdata2_i;
	assign slot2_if.excepttype = excepttype2_i;
	assign slot2_if.pc = pc2_i;
	assign slot2_if.in_delay = in_delay2_i;
	assign slot2_if.bad_addr = bad_addr2_i;

	cp0_slot_arbiter u_arbiter (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.hold_i(hold_i),
		.slot1(slot1_if.arbiter),
		.slot2(slot2_if.arbiter),
		.commit(commit_if.source)
	);

	cp0_timer u_timer (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.commit(commit_if.sink),
		.count_o(count_o),
		.compare_o(compare),
		.timer_int_o(timer_int_o)
	);

	cp0_regs u_regs (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.commit(commit_if.sink),
		.int_i(int_i),
		.timer_int_i(timer_int_o),
		.count_i(count_o),
		.compare_i(compare),
		.raddr1_i(raddr1_i),
		.raddr2_i(raddr2_i),
		.rdata1_o(rdata1_o),
		.rdata2_o(rdata2_o),
		.status_o(status_o),
		.cause_o(cause_o),
		.epc_o(epc_o)
	);

endmodule

// File: verification/cp0_tb.sv
`timescale 1ns/10ps

module cp0_tb;

	typedef struct packed {
		logic we;
		logic [cp0_pkg::ADDR_W-1:0] waddr;
		logic [cp0_pkg::REG_W-1:0] wdata;
		logic [cp0_pkg::REG_W-1:0] etype;
		logic [cp0_pkg::REG_W-1:0] pc;
		logic in_delay;
		logic [cp0_pkg::REG_W-1:0] bad_addr;
	} slot_t;

	typedef struct packed {
		slot_t s1;
		slot_t s2;
		logic hold;
		logic [cp0_pkg::INT_W-1:0] intr;
		logic [cp0_pkg::ADDR_W-1:0] raddr;
		logic [cp0_pkg::REG_W-1:0] expected;
		logic tint; // expected timer_int_o
		logic wait_tint; // wait for the timer interrupt first
	} step_t;

	logic clk;
	logic rst_n_i;
	logic hold_i;
	logic we1_i;
	logic [cp0_pkg::ADDR_W-1:0] waddr1_i;
	logic [cp0_pkg::REG_W-1:0] wdata1_i;
	logic [cp0_pkg::REG_W-1:0] excepttype1_i;
	logic [cp0_pkg::REG_W-1:0] pc1_i;
	logic in_delay1_i;
	logic [cp0_pkg::REG_W-1:0] bad_addr1_i;
	logic we2_i;
	logic [cp0_pkg::ADDR_W-1:0] waddr2_i;
	logic [cp0_pkg::REG_W-1:0] wdata2_i;
	logic [cp0_pkg::REG_W-1:0] excepttype2_i;
	logic [cp0_pkg::REG_W-1:0] pc2_i;
	logic in_delay2_i;
	logic [cp0_pkg::REG_W-1:0] bad_addr2_i;
	logic [cp0_pkg::INT_W-1:0] int_i;
	logic [cp0_pkg::ADDR_W-1:0] raddr1_i;
	logic [cp0_pkg::ADDR_W-1:0] raddr2_i;
	logic [cp0_pkg::REG_W-1:0] rdata1_o;
	logic [cp0_pkg::REG_W-1:0] rdata2_o;
	logic [cp0_pkg::REG_W-1:0] status_o;
	logic [cp0_pkg::REG_W-1:0] cause_o;
	logic [cp0_pkg::REG_W-1:0] epc_o;
	logic [cp0_pkg::REG_W-1:0] count_o;
	logic timer_int_o;
	int seed;
	int errors;
	int checks;
	step_t steps[$];
	string names[$];

	cp0_top UUT (.*);

	always #5 clk = ~clk;

	function automatic slot_t wr_op(input logic [4:0] addr, input logic [31:0] data);
		return '{we: 1'b1, waddr: addr, wdata: data, default: '0};
	endfunction

	function automatic slot_t exc_op(input logic [31:0] code, input logic [31:0] addr,
		input logic dly, input logic [31:0] bad);
		return '{etype: code, pc: addr, in_delay: dly, bad_addr: bad, default: '0};
	endfunction

	// fields the DUT ignores get random values
	function automatic slot_t fill_random(input slot_t s);
		if (!s.we) begin
			s.waddr = 5'($random(seed));
			s.wdata = $random(seed);
		end
		if (s.etype == '0) begin
			s.pc = $random(seed);
			s.in_delay = 1'($random(seed));
			s.bad_addr = $random(seed);
		end
		return s;
	endfunction

	task automatic drive_slots(input slot_t a, input slot_t b);
		{we1_i, waddr1_i, wdata1_i, excepttype1_i, pc1_i, in_delay1_i, bad_addr1_i} =
			fill_random(a);
		{we2_i, waddr2_i, wdata2_i, excepttype2_i, pc2_i, in_delay2_i, bad_addr2_i} =
			fill_random(b);
	endtask

	task automatic add_step(input string name, input logic [4:0] raddr, input logic [31:0] exp_v,
		input slot_t a = '0, input slot_t b = '0, input logic hold = 1'b0,
		input logic [5:0] intr = '0, input logic tint = 1'b0, input logic wt = 1'b0);
		names.push_back(name);
		steps.push_back({a, b, hold, intr, raddr, exp_v, tint, wt});
	endtask

	task automatic wait_timer_int(input int max_cycles);
		int n;
		n = 0;
		drive_slots('0, '0); // idle so Count keeps running
		while (timer_int_o !== 1'b1 && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (timer_int_o !== 1'b1) begin
			$display("timer interrupt did not rise within %0d cycles", max_cycles);
			errors++;
		end
	endtask

	task automatic check_step(input int i);
		logic [cp0_pkg::REG_W-1:0] direct;
		logic has_direct;
		has_direct = 1'b1;
		case (steps[i].raddr) // registers that also have their own output
			cp0_pkg::CP0_STATUS: direct = status_o;
			cp0_pkg::CP0_CAUSE: direct = cause_o;
			cp0_pkg::CP0_EPC: direct = epc_o;
			cp0_pkg::CP0_COUNT: direct = count_o;
			default: begin
				has_direct = 1'b0;
				direct = '0;
			end
		endcase
		checks += 2;
		assert (rdata1_o === steps[i].expected && rdata2_o === steps[i].expected) else begin
			$display("[FAIL] %s: expected %h, actual %h and %h", names[i], steps[i].expected,
				rdata1_o, rdata2_o);
			errors++;
		end
		assert (timer_int_o === steps[i].tint) else begin
			$display("[FAIL] %s timer_int: expected %b, actual %b", names[i], steps[i].tint,
				timer_int_o);
			errors++;
		end
		if (has_direct) begin
			checks++;
			assert (direct === steps[i].expected) else begin
				$display("[FAIL] %s output port: expected %h, actual %h", names[i],
					steps[i].expected, direct);
				errors++;
			end
		end
	endtask

	task automatic build_table();
		add_step("reset_count", cp0_pkg::CP0_COUNT, 32'h0); // one cycle, half a tick
		add_step("reset_status", cp0_pkg::CP0_STATUS, 32'h00400000);
		add_step("reset_config", cp0_pkg::CP0_CONFIG, 32'h00008000);
		add_step("reset_prid", cp0_pkg::CP0_PRID, 32'h004c0102);
		add_step("reset_cause", cp0_pkg::CP0_CAUSE, 32'h0);
		add_step("reset_epc", cp0_pkg::CP0_EPC, 32'h0);
		add_step("reset_compare", cp0_pkg::CP0_COMPARE, 32'h0);
		add_step("status_wr", cp0_pkg::CP0_STATUS, 32'h0000ff01,
			wr_op(cp0_pkg::CP0_STATUS, 32'h0000ff01));
		add_step("cause_mask", cp0_pkg::CP0_CAUSE, 32'h00c00300, // bits 23:22, 9:8 only
			wr_op(cp0_pkg::CP0_CAUSE, 32'hffffffff));
		add_step("epc_both", cp0_pkg::CP0_EPC, 32'h22220000,
			wr_op(cp0_pkg::CP0_EPC, 32'h11110000), wr_op(cp0_pkg::CP0_EPC, 32'h22220000));
		add_step("sys_epc", cp0_pkg::CP0_EPC, 32'h00001000,
			exc_op(cp0_pkg::EXC_T_SYS, 32'h00001000, 1'b0, 32'h0));
		add_step("sys_cause", cp0_pkg::CP0_CAUSE, 32'h00c00320); // bd 0, code 8
		add_step("sys_exl", cp0_pkg::CP0_STATUS, 32'h0000ff03);
		add_step("eret_status", cp0_pkg::CP0_STATUS, 32'h0000ff01,
			exc_op(cp0_pkg::EXC_T_ERET, 32'h0, 1'b0, 32'h0));
		add_step("eret_epc", cp0_pkg::CP0_EPC, 32'h00001000);
		add_step("adel_epc", cp0_pkg::CP0_EPC, 32'h00002000, // pc - 4 in delay slot
			exc_op(cp0_pkg::EXC_T_ADEL, 32'h00002004, 1'b1, 32'hdeadbeef));
		add_step("adel_cause", cp0_pkg::CP0_CAUSE, 32'h80c00310); // bd 1, code 4
		add_step("adel_badvaddr", cp0_pkg::CP0_BADVADDR, 32'hdeadbeef);
		add_step("both_exc", cp0_pkg::CP0_EPC, 32'h00003000,
			exc_op(cp0_pkg::EXC_T_BP, 32'h00003000, 1'b0, 32'h0),
			exc_op(cp0_pkg::EXC_T_SYS, 32'h00004000, 1'b1, 32'h0));
		add_step("hold_status", cp0_pkg::CP0_STATUS, 32'h0000ff03,
			wr_op(cp0_pkg::CP0_STATUS, 32'h0000aa01), '0, 1'b1);
		add_step("hold_count", cp0_pkg::CP0_COUNT, 32'd9, // 19 enabled cycles so far
			wr_op(cp0_pkg::CP0_STATUS, 32'h0000aa01), '0, 1'b1);
		add_step("hold_release", cp0_pkg::CP0_STATUS, 32'h0000aa01,
			wr_op(cp0_pkg::CP0_STATUS, 32'h0000aa01));
		add_step("count_wr", cp0_pkg::CP0_COUNT, 32'h00000100,
			wr_op(cp0_pkg::CP0_COUNT, 32'h00000100));
		add_step("count_run1", cp0_pkg::CP0_COUNT, 32'h00000100);
		add_step("count_run2", cp0_pkg::CP0_COUNT, 32'h00000101);
		add_step("compare_wr", cp0_pkg::CP0_COMPARE, 32'h00000103,
			wr_op(cp0_pkg::CP0_COMPARE, 32'h00000103));
		add_step("timer_cause", cp0_pkg::CP0_CAUSE, 32'h00c08324, // ip7 set
			'0, '0, 1'b0, '0, 1'b1, 1'b1);
		add_step("compare_clr", cp0_pkg::CP0_COMPARE, 32'h0,
			wr_op(cp0_pkg::CP0_COMPARE, 32'h0));
		add_step("int_cause", cp0_pkg::CP0_CAUSE, 32'h00c01724, '0, '0, 1'b0, 6'b000101);
	endtask

	initial begin
		seed = 32'h1b4c;
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst_n_i = 1'b0;
		hold_i = 1'b0;
		int_i = '0;
		raddr1_i = '0;
		raddr2_i = '0;
		drive_slots('0, '0);
		build_table();
		repeat (2) @(negedge clk);
		rst_n_i = 1'b1;
		foreach (steps[i]) begin
			if (steps[i].wait_tint) begin
				wait_timer_int(20);
			end
			drive_slots(steps[i].s1, steps[i].s2);
			hold_i = steps[i].hold;
			int_i = steps[i].intr;
			raddr1_i = steps[i].raddr;
			raddr2_i = steps[i].raddr;
			@(negedge clk);
			check_step(i);
		end
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: cp0_sys.f
verilog/cp0_pkg.sv
verilog/cp0_slot_if.sv
verilog/cp0_commit_if.sv
verilog/cp0_slot_arbiter.sv
verilog/cp0_timer.sv
verilog/cp0_regs.sv
verilog/cp0_top.sv
verification/cp0_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP ?= cp0_tb
DUT_TOP ?= cp0_top
FILELIST ?= cp0_sys.f
OBJ_DIR ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG ?= Test OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
